// ==== isa_pkg.sv ====
package isa_pkg;

  // Instruction field widths.
  localparam int OPCODE_W   = 6;
  localparam int FUNCT_W    = 6;
  localparam int REG_ADDR_W = 5;
  localparam int SHAMT_W    = 5;
  localparam int IMM_W      = 16;
  localparam int JIDX_W     = 26;  // Word index of a J target.

  // Primary opcodes, bits 31:26.
  typedef enum logic [OPCODE_W-1:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_SLTI  = 6'h0A,
    OP_ANDI  = 6'h0C,
    OP_ORI   = 6'h0D,
    OP_XORI  = 6'h0E,
    OP_LUI   = 6'h0F,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2B
  } opcode_t;

  // Function codes of R-type words, bits 5:0.
  typedef enum logic [FUNCT_W-1:0] {
    F_SLL  = 6'h00,
    F_SRL  = 6'h02,
    F_JR   = 6'h08,
    F_ADDU = 6'h21,
    F_SUBU = 6'h23,
    F_AND  = 6'h24,
    F_OR   = 6'h25,
    F_XOR  = 6'h26,
    F_SLT  = 6'h2A
  } funct_t;

endpackage

// ==== cpu_pkg.sv ====
package cpu_pkg;

  // Sequencer states.
  typedef enum logic [2:0] {
    S_FETCH,
    S_DECODE,
    S_EXEC,
    S_MEM,
    S_WB,
    S_HALT
  } state_t;

  // ALU operations.
  typedef enum logic [3:0] {
    A_ADD, A_SUB, A_AND, A_OR, A_XOR, A_SLT, A_SLL, A_SRL, A_LUI
  } alu_op_t;

endpackage

// ==== fsm.sv ====
module fsm (
  input  logic             clk,
  input  logic             rst_i,
  input  logic             stall_i,
  input  logic             is_mem_i,
  input  logic             is_halt_i,
  output cpu_pkg::state_t  state_o,
  output logic             active_o
);
  import cpu_pkg::*;

  state_t state_q, state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_FETCH:  if (!stall_i) state_d = S_DECODE;
      S_DECODE: state_d = S_EXEC;
      S_EXEC: begin
        if (is_halt_i) state_d = S_HALT;
        else if (is_mem_i) state_d = S_MEM;
        else state_d = S_WB;
      end
      // Loads go on to write-back, stores straight to the next fetch.
      S_MEM:    if (!stall_i) state_d = is_mem_i ? S_WB : S_FETCH;
      S_WB:     state_d = S_FETCH;
      S_HALT:   if (active_o) state_d = S_FETCH;  // Parked here by reset only.
      default:  state_d = S_FETCH;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q  <= S_HALT;  // Idle with no bus request during reset.
      active_o <= 1'b1;
    end else begin
      state_q <= state_d;
      if (state_d == S_HALT) active_o <= 1'b0;
    end
  end

  assign state_o = state_q;

endmodule

// ==== control.sv ====
module control (
  input  cpu_pkg::state_t   state_i,
  input  isa_pkg::opcode_t  opcode_i,
  input  isa_pkg::funct_t   funct_i,
  input  logic              halt_jump_i,
  output logic              pc_wen_o, ir_wen_o, reg_wen_o, reg_dst_rd_o, reg_from_mem_o,
  output logic              alu_src_imm_o, mem_addr_sel_o,
  output logic              branch_eq_o, branch_ne_o, jump_o, jump_reg_o,
  output logic              read_o, write_o, is_mem_o, is_halt_o,
  output cpu_pkg::alu_op_t  alu_op_o
);
  import isa_pkg::*;
  import cpu_pkg::*;

  logic rtype, is_load, is_store, writes_reg;

  assign rtype    = (opcode_i == OP_RTYPE);
  assign is_load  = (opcode_i == OP_LW);
  assign is_store = (opcode_i == OP_SW);

  assign branch_eq_o = (opcode_i == OP_BEQ);
  assign branch_ne_o = (opcode_i == OP_BNE);
  assign jump_o      = (opcode_i == OP_J);
  assign jump_reg_o  = rtype && (funct_i == F_JR);

  assign alu_src_imm_o  = !rtype && !branch_eq_o && !branch_ne_o;
  assign reg_dst_rd_o   = rtype;
  assign reg_from_mem_o = is_load;
  assign writes_reg = rtype ? !jump_reg_o
                            : !(is_load || is_store || branch_eq_o || branch_ne_o || jump_o);

  assign ir_wen_o       = (state_i == S_FETCH);
  assign pc_wen_o       = (state_i == S_EXEC);  // Every instruction moves PC here.
  assign mem_addr_sel_o = (state_i == S_MEM);
  assign read_o  = (state_i == S_FETCH) || (state_i == S_MEM && is_load);
  assign write_o = (state_i == S_MEM) && is_store;
  // Load data is written as the read completes.
  assign reg_wen_o = (state_i == S_WB && writes_reg) || (state_i == S_MEM && is_load);

  // In S_MEM this flags a load, which still needs its write-back slot.
  assign is_mem_o  = (state_i == S_MEM) ? is_load : (is_load || is_store);
  assign is_halt_o = (state_i == S_EXEC) && halt_jump_i;

  always_comb begin
    alu_op_o = A_ADD;  // Addresses, ADDU, ADDIU.
    case (opcode_i)
      OP_RTYPE: begin
        case (funct_i)
          F_SUBU:  alu_op_o = A_SUB;
          F_AND:   alu_op_o = A_AND;
          F_OR:    alu_op_o = A_OR;
          F_XOR:   alu_op_o = A_XOR;
          F_SLT:   alu_op_o = A_SLT;
          F_SLL:   alu_op_o = A_SLL;
          F_SRL:   alu_op_o = A_SRL;
          default: alu_op_o = A_ADD;
        endcase
      end
      OP_BEQ, OP_BNE: alu_op_o = A_SUB;
      OP_SLTI: alu_op_o = A_SLT;
      OP_ANDI: alu_op_o = A_AND;
      OP_ORI:  alu_op_o = A_OR;
      OP_XORI: alu_op_o = A_XOR;
      OP_LUI:  alu_op_o = A_LUI;
      default: alu_op_o = A_ADD;
    endcase
  end

endmodule

// ==== pc.sv ====
module pc #(
  parameter logic [31:0] RESET_VECTOR = 32'hBFC00000
) (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        wen_i,
  input  logic        branch_eq_i, branch_ne_i, jump_i, jump_reg_i, zero_i,
  input  logic [31:0] offset_i, target_i, rs_data_i,
  output logic [31:0] pc_o,
  output logic        halt_jump_o
);

  logic [31:0] pc_q, pc_plus4, pc_next;
  logic        taken;

  assign pc_plus4 = pc_q + 32'd4;
  assign taken    = (branch_eq_i && zero_i) || (branch_ne_i && !zero_i);

  always_comb begin
    if (jump_reg_i) pc_next = rs_data_i;
    else if (jump_i) pc_next = {pc_plus4[31:28], target_i[27:0]};  // Same 256 MB region.
    else if (taken) pc_next = pc_plus4 + {offset_i[29:0], 2'b00};
    else pc_next = pc_plus4;
  end

  always_ff @(posedge clk) begin
    if (rst_i) pc_q <= RESET_VECTOR;
    else if (wen_i) pc_q <= pc_next;
  end

  assign halt_jump_o = (jump_i || jump_reg_i) && (pc_next == 32'd0);
  assign pc_o        = pc_q;

endmodule

// ==== ir.sv ====
module ir (
  input  logic                            clk,
  input  logic                            rst_i,
  input  logic                            wen_i,
  input  logic [31:0]                     instr_i,
  output isa_pkg::opcode_t                opcode_o,
  output isa_pkg::funct_t                 funct_o,
  output logic [isa_pkg::REG_ADDR_W-1:0]  rs_o, rt_o, rd_o,
  output logic [isa_pkg::SHAMT_W-1:0]     shamt_o,
  output logic [31:0]                     imm_sext_o, imm_zext_o, jtarget_o
);
  import isa_pkg::*;

  logic [31:0]      instr_q;
  logic [IMM_W-1:0] imm;

  always_ff @(posedge clk) begin
    if (rst_i) instr_q <= '0;
    else if (wen_i) instr_q <= instr_i;
  end

  assign opcode_o = opcode_t'(instr_q[31 -: OPCODE_W]);
  assign rs_o     = instr_q[25:21];
  assign rt_o     = instr_q[20:16];
  assign rd_o     = instr_q[15:11];
  assign shamt_o  = instr_q[10:6];
  assign funct_o  = funct_t'(instr_q[FUNCT_W-1:0]);

  assign imm        = instr_q[IMM_W-1:0];
  assign imm_sext_o = {{(32 - IMM_W){imm[IMM_W-1]}}, imm};
  assign imm_zext_o = {{(32 - IMM_W){1'b0}}, imm};
  assign jtarget_o  = {{(30 - JIDX_W){1'b0}}, instr_q[JIDX_W-1:0], 2'b00};  // Low 28 bits.

endmodule

// ==== regfile.sv ====
module regfile (
  input  logic                            clk,
  input  logic                            rst_i,
  input  logic                            wen_i,
  input  logic [isa_pkg::REG_ADDR_W-1:0]  addr_1_i, addr_2_i, addr_3_i,
  input  logic [31:0]                     write_data_3_i,
  output logic [31:0]                     read_data_1_o, read_data_2_o, v0_o
);
  import isa_pkg::*;

  localparam int NREGS = 2 ** REG_ADDR_W;

  logic [31:0] regs [NREGS];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && addr_3_i != '0) begin  // $zero stays zero.
      regs[addr_3_i] <= write_data_3_i;
    end
  end

  assign read_data_1_o = regs[addr_1_i];
  assign read_data_2_o = regs[addr_2_i];
  assign v0_o          = regs[2];

endmodule

// ==== alu.sv ====
module alu (
  input  cpu_pkg::alu_op_t  op_i,
  input  logic              src_imm_i,
  input  logic              logic_imm_i,
  input  logic              from_mem_i,
  input  logic [31:0]       a_i, b_i, imm_sext_i, imm_zext_i, mem_data_i,
  input  logic [4:0]        shamt_i,
  output logic [31:0]       result_o, wb_data_o,
  output logic              zero_o
);
  import cpu_pkg::*;

  logic [31:0] imm, op_b;

  assign imm  = logic_imm_i ? imm_zext_i : imm_sext_i;
  assign op_b = src_imm_i ? imm : b_i;

  always_comb begin
    case (op_i)
      A_ADD:   result_o = a_i + op_b;
      A_SUB:   result_o = a_i - op_b;
      A_AND:   result_o = a_i & op_b;
      A_OR:    result_o = a_i | op_b;
      A_XOR:   result_o = a_i ^ op_b;
      A_SLT:   result_o = {31'd0, $signed(a_i) < $signed(op_b)};
      A_SLL:   result_o = op_b << shamt_i;  // Shifts take rt, not rs.
      A_SRL:   result_o = op_b >> shamt_i;
      A_LUI:   result_o = {op_b[15:0], 16'h0000};
      default: result_o = a_i + op_b;
    endcase
  end

  // Branch compare on rs and rt.
  assign zero_o = (a_i == op_b);

  assign wb_data_o = from_mem_i ? mem_data_i : result_o;

endmodule

// ==== mips_cpu_bus.sv ====
module mips_cpu_bus #(
  parameter logic [31:0] RESET_VECTOR = 32'hBFC00000
) (
  input  logic        clk,
  input  logic        rst_i,
  output logic        active_o,
  output logic [31:0] register_v0_o,

  // Avalon master.
  output logic [31:0] address_o,
  output logic        write_o,
  output logic        read_o,
  input  logic        waitrequest_i,
  output logic [31:0] writedata_o,
  input  logic [31:0] readdata_i
);
  import isa_pkg::*;
  import cpu_pkg::*;

  state_t  state;
  opcode_t opcode;
  funct_t  funct;
  alu_op_t alu_op;
  logic is_mem, is_halt, halt_jump;
  logic pc_wen, ir_wen, reg_wen, reg_dst_rd, reg_from_mem, alu_src_imm, mem_addr_sel;
  logic branch_eq, branch_ne, jump, jump_reg;
  logic xfer_wait, ir_load, reg_load, logic_imm, alu_zero;
  logic [REG_ADDR_W-1:0] rs, rt, rd, reg_waddr;
  logic [SHAMT_W-1:0] shamt;
  logic [31:0] pc_q, imm_sext, imm_zext, jtarget;
  logic [31:0] rdata_1, rdata_2, alu_result, wb_data;

  // Loads into IR and registers only land when the bus transfer completes.
  assign xfer_wait = (read_o | write_o) & waitrequest_i;
  assign ir_load   = ir_wen & ~xfer_wait;
  assign reg_load  = reg_wen & ~xfer_wait;
  assign reg_waddr = reg_dst_rd ? rd : rt;
  assign logic_imm = alu_op inside {A_AND, A_OR, A_XOR};  // ANDI/ORI/XORI zero-extend.

  fsm u_fsm (
    .clk(clk), .rst_i(rst_i), .stall_i(waitrequest_i), .is_mem_i(is_mem),
    .is_halt_i(is_halt), .state_o(state), .active_o(active_o)
  );

  control u_control (
    .state_i(state), .opcode_i(opcode), .funct_i(funct), .halt_jump_i(halt_jump),
    .pc_wen_o(pc_wen), .ir_wen_o(ir_wen), .reg_wen_o(reg_wen), .reg_dst_rd_o(reg_dst_rd),
    .reg_from_mem_o(reg_from_mem), .alu_src_imm_o(alu_src_imm),
    .mem_addr_sel_o(mem_addr_sel), .branch_eq_o(branch_eq), .branch_ne_o(branch_ne),
    .jump_o(jump), .jump_reg_o(jump_reg), .read_o(read_o), .write_o(write_o),
    .is_mem_o(is_mem), .is_halt_o(is_halt), .alu_op_o(alu_op)
  );

  pc #(.RESET_VECTOR(RESET_VECTOR)) u_pc (
    .clk(clk), .rst_i(rst_i), .wen_i(pc_wen), .branch_eq_i(branch_eq),
    .branch_ne_i(branch_ne), .jump_i(jump), .jump_reg_i(jump_reg), .zero_i(alu_zero),
    .offset_i(imm_sext), .target_i(jtarget), .rs_data_i(rdata_1),
    .pc_o(pc_q), .halt_jump_o(halt_jump)
  );

  ir u_ir (
    .clk(clk), .rst_i(rst_i), .wen_i(ir_load), .instr_i(readdata_i),
    .opcode_o(opcode), .funct_o(funct), .rs_o(rs), .rt_o(rt), .rd_o(rd), .shamt_o(shamt),
    .imm_sext_o(imm_sext), .imm_zext_o(imm_zext), .jtarget_o(jtarget)
  );

  regfile u_regfile (
    .clk(clk), .rst_i(rst_i), .wen_i(reg_load), .addr_1_i(rs), .addr_2_i(rt),
    .addr_3_i(reg_waddr), .write_data_3_i(wb_data), .read_data_1_o(rdata_1),
    .read_data_2_o(rdata_2), .v0_o(register_v0_o)
  );

  alu u_alu (
    .op_i(alu_op), .src_imm_i(alu_src_imm), .logic_imm_i(logic_imm),
    .from_mem_i(reg_from_mem), .a_i(rdata_1), .b_i(rdata_2), .imm_sext_i(imm_sext),
    .imm_zext_i(imm_zext), .mem_data_i(readdata_i), .shamt_i(shamt),
    .result_o(alu_result), .wb_data_o(wb_data), .zero_o(alu_zero)
  );

  assign address_o   = mem_addr_sel ? alu_result : pc_q;  // Data address or fetch.
  assign writedata_o = rdata_2;

endmodule

// ==== tb_avalon_mem.sv ====
module tb_avalon_mem (
  input  logic        clk,
  input  logic [31:0] address_i,
  input  logic        read_i,
  input  logic        write_i,
  input  logic [31:0] writedata_i,
  output logic        waitrequest_o,
  output logic [31:0] readdata_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WORDS = 1024;  // 4 KB, program and data.

  logic [31:0] mem [WORDS];
  logic [31:0] rand_state;
  logic        busy;
  int          remaining;

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin
    rand_state    = 32'h70fb;
    busy          = 1'b0;
    remaining     = 0;
    waitrequest_o = 1'b0;
  end

  assign readdata_o = mem[address_i[11:2]];

  // Stall count is drawn when a new request shows up.
  always @(negedge clk) begin
    if (read_i || write_i) begin
      if (!busy) begin
        busy          = 1'b1;
        rand_state    = xorshift(rand_state);
        remaining     = int'(rand_state[1:0]);  // 0 to 3 cycles.
        waitrequest_o = (remaining != 0);
      end else if (remaining != 0) begin
        remaining     = remaining - 1;
        waitrequest_o = (remaining != 0);
      end
    end else begin
      busy          = 1'b0;
      waitrequest_o = 1'b0;
    end
  end

  always @(posedge clk) begin
    if ((read_i || write_i) && !waitrequest_o) begin
      if (write_i) mem[address_i[11:2]] = writedata_i;
      busy = 1'b0;  // Transfer done.
    end
  end

endmodule

// ==== mips_cpu_bus_assertions.sv ====
module mips_cpu_bus_assertions (
  input logic        clk,
  input logic        rst_i,
  input logic        active_i,
  input logic        read_i,
  input logic        write_i,
  input logic        waitrequest_i,
  input logic [31:0] address_i,
  input logic [31:0] writedata_i
);
  timeunit 1ns;
  timeprecision 1ps;

  a_no_read_write: assert property (@(posedge clk) disable iff (rst_i)
    !(read_i && write_i)) else $error("read and write high together");

  a_addr_stable: assert property (@(posedge clk) disable iff (rst_i)
    (read_i || write_i) && waitrequest_i |=> $stable(address_i))
    else $error("address changed during a stalled transfer");

  a_wdata_stable: assert property (@(posedge clk) disable iff (rst_i)
    write_i && waitrequest_i |=> $stable(writedata_i))
    else $error("write data changed during a stalled write");

  a_idle_after_halt: assert property (@(posedge clk) disable iff (rst_i)
    !active_i |-> !read_i && !write_i) else $error("bus transfer after halt");

  a_aligned: assert property (@(posedge clk) disable iff (rst_i)
    (read_i || write_i) |-> address_i[1:0] == 2'b00)
    else $error("unaligned bus address");

endmodule

bind mips_cpu_bus mips_cpu_bus_assertions u_assertions (
  .clk(clk), .rst_i(rst_i), .active_i(active_o), .read_i(read_o), .write_i(write_o),
  .waitrequest_i(waitrequest_i), .address_i(address_o), .writedata_i(writedata_o)
);

// ==== tb_mips_cpu_bus.sv ====
module tb_mips_cpu_bus;
  timeunit 1ns;
  timeprecision 1ps;
  import isa_pkg::*;

  localparam logic [31:0] BASE = 32'h00000100;
  localparam logic [4:0] ZERO = 5'd0;
  localparam logic [4:0] V0 = 5'd2;
  localparam logic [4:0] T0 = 5'd8;
  localparam logic [4:0] T1 = 5'd9;
  localparam logic [4:0] T2 = 5'd10;
  localparam logic [4:0] T3 = 5'd11;

  logic clk, rst_i, active, read, write, waitrequest;
  logic [31:0] v0, address, writedata, readdata;
  int errors, checks, prog_ptr;

  mips_cpu_bus #(.RESET_VECTOR(BASE)) u_dut (
    .clk(clk), .rst_i(rst_i), .active_o(active), .register_v0_o(v0),
    .address_o(address), .write_o(write), .read_o(read), .waitrequest_i(waitrequest),
    .writedata_o(writedata), .readdata_i(readdata)
  );

  tb_avalon_mem u_mem (
    .clk(clk), .address_i(address), .read_i(read), .write_i(write),
    .writedata_i(writedata), .waitrequest_o(waitrequest), .readdata_o(readdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] rtype_word(funct_t f, logic [4:0] rd, logic [4:0] rs,
                                             logic [4:0] rt, logic [4:0] shamt);
    return {OP_RTYPE, rs, rt, rd, shamt, f};
  endfunction

  function automatic logic [31:0] itype_word(opcode_t op, logic [4:0] rt, logic [4:0] rs,
                                             logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jump_word(logic [31:0] target);
    return {OP_J, target[27:2]};
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Fill the whole memory with an address pattern and restart the program.
  task automatic clear_memory();
    for (int i = 0; i < 1024; i++) begin
      u_mem.mem[i] = 32'hC0DE0000 ^ i;
    end
    prog_ptr = 0;
  endtask

  task automatic put_word(logic [31:0] w);
    u_mem.mem[BASE[11:2] + prog_ptr] = w;
    prog_ptr++;
  endtask

  function automatic logic [31:0] word_addr(int idx);
    return BASE + 32'(idx * 4);
  endfunction

  // Ends the program, resets the CPU and waits for the halt.
  task automatic run_program();
    int cycles;
    put_word(rtype_word(F_JR, ZERO, ZERO, ZERO, 5'd0));
    @(negedge clk);
    rst_i = 1'b1;
    repeat (2) @(negedge clk);
    rst_i = 1'b0;
    cycles = 0;
    while (active && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    if (active) begin
      errors++;
      $display("CPU did not halt within 2000 cycles");
    end
  endtask

  task automatic rtype_case(string name, funct_t f, logic [4:0] rs, logic [4:0] rt,
                            logic [4:0] shamt, logic [31:0] expected);
    clear_memory();
    put_word(itype_word(OP_ADDIU, T0, ZERO, 16'h1234));
    put_word(itype_word(OP_ADDIU, T1, ZERO, 16'hFFFB));
    put_word(rtype_word(f, V0, rs, rt, shamt));
    run_program();
    check_value(name, expected, v0);
  endtask

  task automatic rtype_ops_test();
    logic [31:0] a, b;
    a = 32'h00001234;
    b = 32'hFFFFFFFB;  // -5.
    rtype_case("addu", F_ADDU, T0, T1, 5'd0, a + b);
    rtype_case("subu", F_SUBU, T0, T1, 5'd0, a - b);
    rtype_case("and", F_AND, T0, T1, 5'd0, a & b);
    rtype_case("or", F_OR, T0, T1, 5'd0, a | b);
    rtype_case("xor", F_XOR, T0, T1, 5'd0, a ^ b);
    rtype_case("slt_false", F_SLT, T0, T1, 5'd0, 32'd0);
    rtype_case("slt_true", F_SLT, T1, T0, 5'd0, 32'd1);
    rtype_case("sll", F_SLL, ZERO, T1, 5'd4, b << 4);
    rtype_case("srl", F_SRL, ZERO, T1, 5'd4, b >> 4);
  endtask

  task automatic immediate_case(string name, opcode_t op, logic [15:0] base,
                                logic [15:0] imm, logic [31:0] expected);
    clear_memory();
    put_word(itype_word(OP_ADDIU, T0, ZERO, base));
    put_word(itype_word(op, V0, T0, imm));
    run_program();
    check_value(name, expected, v0);
  endtask

  task automatic immediate_ops_test();
    logic [31:0] a, n;
    a = 32'h000000F0;
    n = 32'hFFFFFFF0;  // Upper half set so a sign-extended mask would show.
    immediate_case("addiu_neg", OP_ADDIU, 16'h00F0, 16'hFF9C, a - 32'd100);
    immediate_case("andi", OP_ANDI, 16'hFFF0, 16'h80F3, n & 32'h000080F3);
    immediate_case("ori", OP_ORI, 16'h00F0, 16'h8001, a | 32'h00008001);
    immediate_case("xori", OP_XORI, 16'h00F0, 16'hFFFF, a ^ 32'h0000FFFF);
    immediate_case("slti_neg", OP_SLTI, 16'h00F0, 16'h8000, 32'd0);
    immediate_case("slti_pos", OP_SLTI, 16'h00F0, 16'h0100, 32'd1);
    clear_memory();
    put_word(itype_word(OP_LUI, V0, ZERO, 16'hDEAD));
    put_word(itype_word(OP_ORI, V0, V0, 16'hBEEF));
    run_program();
    check_value("lui_ori", 32'hDEADBEEF, v0);
  endtask

  task automatic load_store_test();
    logic [31:0] first, second;
    first  = 32'h3C << 8;
    second = 32'hFFFFFFFE;
    clear_memory();
    put_word(itype_word(OP_ADDIU, T0, ZERO, 16'h0200));  // Data base.
    put_word(itype_word(OP_ADDIU, T1, ZERO, 16'h003C));
    put_word(rtype_word(F_SLL, T1, ZERO, T1, 5'd8));
    put_word(itype_word(OP_SW, T1, T0, 16'h0004));
    put_word(itype_word(OP_ADDIU, T2, ZERO, 16'hFFFE));
    put_word(itype_word(OP_SW, T2, T0, 16'h0008));
    put_word(itype_word(OP_LW, T3, T0, 16'h0004));
    put_word(itype_word(OP_LW, V0, T0, 16'h0008));
    put_word(rtype_word(F_ADDU, V0, V0, T3, 5'd0));
    run_program();
    check_value("lw_sum", first + second, v0);
    check_value("sw_word_1", first, u_mem.mem[(32'h204) >> 2]);
    check_value("sw_word_2", second, u_mem.mem[(32'h208) >> 2]);
  endtask

  // Each skipped word would add a large amount to v0.
  task automatic branch_jump_test();
    clear_memory();
    put_word(itype_word(OP_ADDIU, T0, ZERO, 16'd5));
    put_word(itype_word(OP_ADDIU, T1, ZERO, 16'd5));
    put_word(itype_word(OP_ADDIU, V0, ZERO, 16'd1));
    put_word(itype_word(OP_BEQ, T1, T0, 16'd1));  // Taken.
    put_word(itype_word(OP_ADDIU, V0, V0, 16'd100));
    put_word(itype_word(OP_BNE, T1, T0, 16'd1));  // Not taken.
    put_word(itype_word(OP_ADDIU, V0, V0, 16'd2));
    put_word(itype_word(OP_BEQ, ZERO, T0, 16'd1));  // Not taken.
    put_word(itype_word(OP_ADDIU, V0, V0, 16'd4));
    put_word(itype_word(OP_BNE, ZERO, T0, 16'd1));  // Taken.
    put_word(itype_word(OP_ADDIU, V0, V0, 16'd200));
    put_word(jump_word(word_addr(prog_ptr + 2)));
    put_word(itype_word(OP_ADDIU, V0, V0, 16'd400));
    put_word(itype_word(OP_ADDIU, V0, V0, 16'd8));
    run_program();
    check_value("branch_jump", 32'd1 + 32'd2 + 32'd4 + 32'd8, v0);
  endtask

  task automatic halt_test();
    logic [31:0] v0_at_halt;
    int reads;
    clear_memory();
    put_word(itype_word(OP_ADDIU, V0, ZERO, 16'h0055));
    run_program();
    check_value("halt_v0", 32'h00000055, v0);
    v0_at_halt = v0;
    reads = 0;
    for (int i = 0; i < 50; i++) begin
      @(negedge clk);
      if (read || write) reads++;
      if (active) begin
        errors++;
        $display("active_o rose again after halt");
      end
    end
    check_value("halt_v0_hold", v0_at_halt, v0);
    check_value("halt_bus_idle", 32'd0, 32'(reads));
  endtask

  initial begin
    rst_i  = 1'b1;
    errors = 0;
    checks = 0;
    repeat (2) @(negedge clk);
    rtype_ops_test();
    immediate_ops_test();
    load_store_test();
    branch_jump_test();
    halt_test();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== mips_cpu_bus.f ====
isa_pkg.sv
cpu_pkg.sv
fsm.sv
control.sv
pc.sv
ir.sv
regfile.sv
alu.sv
mips_cpu_bus.sv
tb_avalon_mem.sv
mips_cpu_bus_assertions.sv
tb_mips_cpu_bus.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_mips_cpu_bus \
  -f mips_cpu_bus.f -o sim_mips_cpu_bus
./obj_dir/sim_mips_cpu_bus | tee sim.log
if grep -q "tests failed" sim.log; then
  exit 1
fi
exit 0
